// ==== hdl/trace_consts.svh ====
// trace front end constants
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

////////////////////
// window and lanes

`define TRACE_WINDOW_W      64       // shift window, bits
`define TRACE_LANES         4        // parallel trace pins
`define TRACE_WIDTH_W       3        // trace width field, holds 1/2/4

////////////////////
// match rules

`define TRACE_NUM_RULES     4        // fixed rule count
`define TRACE_COUNT_W       8        // per-rule match counter, wraps

////////////////////
// sync frame detect

// full sync frame is 7fff_ffff on the wire, head checked at the top of the window
`define TRACE_SYNC_HEAD_W   16
`define TRACE_SYNC_HEAD     16'h7fff
`define TRACE_SYNC_TAIL_W   8
`define TRACE_SYNC_TAIL     8'hff    // low byte of the window

// byte alignment counter after lock
// wraps at 8, so width 1 gets one strobe per wrap
`define TRACE_ALIGN_W       3

`endif

// ==== hdl/trace_pkg.sv ====
// trace front end types
`default_nettype none
`include "trace_consts.svh"

package trace_pkg;

   ////////////////////
   // plain vectors

   // window as seen by sync and match logic, bit 0 oldest
   typedef logic [`TRACE_WINDOW_W-1:0] window_t;

   typedef logic [`TRACE_LANES-1:0]     lanes_t;        // raw trace pins
   typedef logic [`TRACE_WIDTH_W-1:0]   trace_width_t;  // 1, 2 or 4 lanes in use
   typedef logic [`TRACE_NUM_RULES-1:0] rule_mask_t;    // one bit per rule
   typedef logic [`TRACE_COUNT_W-1:0]   match_count_t;

   ////////////////////
   // structs

   // one match rule, compare is (window & mask) == (pattern & mask)
   typedef struct packed {
      window_t pattern;
      window_t mask;
      logic    enable;       // rule active
      logic    trig_enable;  // rule may fire trigger, also matches outside capture
   } rule_cfg_t;

   // sync tracker to matcher
   // strobe marks a byte-aligned window while locked
   typedef struct packed {
      window_t window;
      logic    strobe;
   } window_beat_t;

   // captured on every match event
   typedef struct packed {
      rule_mask_t rules;     // which rules hit
      window_t    data;      // window at the strobe
   } match_report_t;

endpackage

`default_nettype wire

// ==== hdl/trace_deserializer.sv ====
// parallel trace deserializer
`default_nettype none
`include "trace_consts.svh"

module trace_deserializer (
   input  wire                          fe_clk,
   input  wire                          reset,
   input  wire trace_pkg::lanes_t       trace_data,
   input  wire trace_pkg::trace_width_t trace_width,
   output trace_pkg::window_t           window
);

   // newest bits enter at bit 0, oldest fall off the top
   trace_pkg::window_t shift_buf;

   ////////////////////
   // shift in

   // target clock mode only, one chunk per fe_clk
   // lane 0 is the earliest bit of each chunk, so it lands highest
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         shift_buf <= '0;
      end
      else begin
         case (trace_width)
            3'd4: begin
               shift_buf <= {shift_buf[`TRACE_WINDOW_W-5:0],
                             trace_data[0],
                             trace_data[1],
                             trace_data[2],
                             trace_data[3]};
            end
            3'd2: begin
               shift_buf <= {shift_buf[`TRACE_WINDOW_W-3:0],
                             trace_data[0],
                             trace_data[1]};   // lanes 2/3 idle
            end
            default: begin
               // width 1, lane 0 only
               shift_buf <= {shift_buf[`TRACE_WINDOW_W-2:0], trace_data[0]};
            end
         endcase
      end
   end

   ////////////////////
   // bit reverse

   // exposed window has the oldest bit at 0
   // so byte order matches the order the target sent it
   always_comb begin
      for (int i = 0; i < `TRACE_WINDOW_W; i++) begin
         window[i] = shift_buf[`TRACE_WINDOW_W-1-i];
      end
   end

   ////////////////////
   // checks

   // width register must hold a legal lane count outside reset
   // any other value would shift by one lane but never strobe
   assert property (@(posedge fe_clk) disable iff (reset)
      trace_width inside {3'd1, 3'd2, 3'd4})
   else
      $error("illegal trace width %0d", trace_width);

endmodule

`default_nettype wire

// ==== hdl/sync_tracker.sv ====
// trace sync lock and byte strobe
`default_nettype none
`include "trace_consts.svh"

module sync_tracker (
   input  wire                          fe_clk,
   input  wire                          reset,
   input  wire trace_pkg::window_t      window,
   input  wire trace_pkg::trace_width_t trace_width,
   input  wire                          resync,
   output logic                         locked,
   output trace_pkg::window_beat_t      beat
);

   trace_pkg::trace_width_t   trace_width_r;   // width of the last shift
   logic [`TRACE_ALIGN_W-1:0] align_cnt;       // chunks past the byte boundary
   logic                      width_change;
   logic                      sync_seen;
   logic                      byte_aligned;
   logic                      strobe;

   ////////////////////
   // lock detect

   assign width_change = (trace_width != trace_width_r);   // old alignment is void

   // head at the top of the window and tail in the low byte
   // catches runs of full or half sync frames
   assign sync_seen =
      (window[`TRACE_WINDOW_W-1 -: `TRACE_SYNC_HEAD_W] == `TRACE_SYNC_HEAD) &&
      (window[`TRACE_SYNC_TAIL_W-1:0] == `TRACE_SYNC_TAIL);

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         locked        <= 1'b0;
         align_cnt     <= '0;
         trace_width_r <= '0;
      end
      else begin
         trace_width_r <= trace_width;
         // resync or a new width drops lock until the next sync frame
         if (resync || width_change) begin
            locked    <= 1'b0;
            align_cnt <= '0;
         end
         else if (!locked && sync_seen) begin
            // lock edge itself shifts one more chunk past the boundary
            locked    <= 1'b1;
            align_cnt <= {{(`TRACE_ALIGN_W-1){1'b0}}, 1'b1};
         end
         else if (locked) begin
            align_cnt <= align_cnt + 1'b1;   // free running and wraps
         end
      end
   end

   ////////////////////
   // byte strobe

   // 8 bits per byte divided by lanes per cycle
   // every 2 cycles at width 4, 4 at width 2, 8 at width 1
   always_comb begin
      case (trace_width_r)
         3'd4:    byte_aligned = (align_cnt[0] == 1'b0);
         3'd2:    byte_aligned = (align_cnt[1:0] == 2'b00);
         3'd1:    byte_aligned = (align_cnt == '0);
         default: byte_aligned = 1'b0;          // never aligned on a bad width
      endcase
   end

   assign strobe = locked && byte_aligned;

   // matcher samples the window on strobe only
   assign beat = '{window: window, strobe: strobe};

   ////////////////////
   // checks

   // strobe only while locked, and never on the first locked cycle
   // that cycle is one chunk past the byte boundary
   assert property (@(posedge fe_clk) disable iff (reset)
      beat.strobe |-> (locked && $past(locked)))
   else
      $error("byte strobe while unlocked");

endmodule

`default_nettype wire

// ==== hdl/pattern_matcher.sv ====
// trace pattern matcher and trigger
`default_nettype none
`include "trace_consts.svh"

module pattern_matcher (
   input  wire                          fe_clk,
   input  wire                          reset,
   input  wire trace_pkg::window_beat_t beat,
   input  wire trace_pkg::rule_cfg_t    rules [`TRACE_NUM_RULES],
   input  wire                          capturing,
   input  wire                          arm,
   input  wire                          ext_trig,
   input  wire                          ext_trig_enable,
   output logic                         match_event,
   output trace_pkg::match_report_t     report,
   output trace_pkg::match_count_t      counts [`TRACE_NUM_RULES],
   output logic                         trigger
);

   trace_pkg::rule_mask_t match_bits;     // strobe qualified hits this cycle
   trace_pkg::rule_mask_t match_bits_r;   // hits at the previous strobe
   trace_pkg::rule_mask_t trig_en;        // per-rule trigger enables
   logic                  capturing_r;
   logic                  ext_trig_r;
   logic                  pattern_edge;
   logic                  ext_edge;

   ////////////////////
   // rule compare

   always_comb begin
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         trig_en[r] = rules[r].trig_enable;
         // trig-enabled rules also match outside capture so they can arm a trigger
         match_bits[r] =
            ((beat.window & rules[r].mask) == (rules[r].pattern & rules[r].mask)) &&
            rules[r].enable &&
            beat.strobe &&
            (capturing_r || rules[r].trig_enable);
      end
   end

   ////////////////////
   // trigger

   // edge taken over strobes rather than cycles
   // a rule that keeps matching byte after byte fires only once
   assign pattern_edge = (arm || capturing) &&
                         (|(match_bits & trig_en)) &&
                         !(|(match_bits_r & trig_en));

   assign ext_edge = ext_trig && !ext_trig_r && ext_trig_enable;   // rising only

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         capturing_r  <= 1'b0;
         ext_trig_r   <= 1'b0;
         match_bits_r <= '0;
         trigger      <= 1'b0;
      end
      else begin
         capturing_r <= capturing;
         ext_trig_r  <= ext_trig;
         if (beat.strobe) begin
            match_bits_r <= match_bits;   // hold between strobes
         end
         trigger <= pattern_edge || ext_edge;
      end
   end

   ////////////////////
   // capture and count

   always_ff @(posedge fe_clk) begin
      if (reset) begin
         match_event <= 1'b0;
         report      <= '0;
      end
      else begin
         match_event <= |match_bits;
         if (|match_bits) begin
            report <= '{rules: match_bits, data: beat.window};   // snapshot at strobe
         end
      end
   end

   // one counter per rule and several may bump together
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
            counts[r] <= '0;
         end
      end
      else begin
         for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
            if (match_bits[r]) begin
               counts[r] <= counts[r] + 1'b1;   // wraps without saturation
            end
         end
      end
   end

   ////////////////////
   // checks

   // pattern edges are a strobe apart and ext edges need a low cycle between
   assert property (@(posedge fe_clk) disable iff (reset)
      trigger |=> !trigger)
   else
      $error("trigger held for two cycles");

endmodule

`default_nettype wire

// ==== hdl/trace_frontend.sv ====
// parallel trace front end top
`default_nettype none
`include "trace_consts.svh"

module trace_frontend (
   input  wire                          fe_clk,
   input  wire                          reset,
   // trace port
   input  wire trace_pkg::lanes_t       trace_data,
   input  wire trace_pkg::trace_width_t trace_width,
   // control levels and pulses
   input  wire                          resync,
   input  wire                          capturing,
   input  wire                          arm,
   input  wire                          ext_trig,
   input  wire                          ext_trig_enable,
   input  wire trace_pkg::rule_cfg_t    rules [`TRACE_NUM_RULES],
   // status and results
   output logic                         locked,
   output logic                         match_event,
   output trace_pkg::match_report_t     report,
   output trace_pkg::match_count_t      counts [`TRACE_NUM_RULES],
   output logic                         trigger
);

   wire trace_pkg::window_t      window;   // bit-reversed shift buffer
   wire trace_pkg::window_beat_t beat;     // window plus byte strobe

   ////////////////////
   // producer

   trace_deserializer u_deser (
      .fe_clk      (fe_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .trace_width (trace_width),
      .window      (window)
   );

   ////////////////////
   // lock and strobe

   sync_tracker u_sync (
      .fe_clk      (fe_clk),
      .reset       (reset),
      .window      (window),
      .trace_width (trace_width),
      .resync      (resync),
      .locked      (locked),
      .beat        (beat)
   );

   ////////////////////
   // consumer

   pattern_matcher u_match (
      .fe_clk          (fe_clk),
      .reset           (reset),
      .beat            (beat),
      .rules           (rules),
      .capturing       (capturing),
      .arm             (arm),
      .ext_trig        (ext_trig),
      .ext_trig_enable (ext_trig_enable),
      .match_event     (match_event),
      .report          (report),
      .counts          (counts),
      .trigger         (trigger)
   );

endmodule

`default_nettype wire

// ==== bench/tb_trace_frontend.sv ====
// trace front end testbench
`default_nettype none
`include "trace_consts.svh"

module tb_trace_frontend;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ENTRIES = 12;
   localparam int CYCLE_LIMIT = NUM_ENTRIES * 80 + 50;

   // one table row per stimulus step
   typedef struct {
      int width;      // lanes in use
      int kind;       // 0 random bytes, 1 sync preamble, 2 fixed bytes
      int value;      // byte for kind 2
      int nbytes;
      int rset;       // rule set index
      int cap;
      int arm;
      int ext;        // one-cycle ext_trig pulse at entry start
      int ext_en;
      int resync;     // one-cycle resync pulse at entry start
      int exp_locked; // locked at entry end
      int exp_trigs;  // trigger pulses seen inside the entry
   } entry_t;

   logic                    fe_clk;
   logic                    reset;
   trace_pkg::lanes_t       trace_data;
   trace_pkg::trace_width_t trace_width;
   logic                    resync, capturing, arm, ext_trig, ext_trig_enable;
   trace_pkg::rule_cfg_t    rules [`TRACE_NUM_RULES];
   logic                    locked, match_event, trigger;
   trace_pkg::match_report_t report;
   trace_pkg::match_count_t  counts [`TRACE_NUM_RULES];

   // reference model state as of the last rising edge
   trace_pkg::window_t       m_buf;
   trace_pkg::trace_width_t  m_width_r;
   logic [`TRACE_ALIGN_W-1:0] m_align;
   logic                     m_locked, m_cap_r, m_ext_r, m_trig, m_event;
   trace_pkg::rule_mask_t    m_bits_r;
   trace_pkg::match_report_t m_report;
   trace_pkg::match_count_t  m_counts [`TRACE_NUM_RULES];

   entry_t      tbl [NUM_ENTRIES];
   int          errors = 0;
   int          cycles = 0;
   int          trig_seen;
   logic [31:0] lcg_state = 32'd49;

   trace_frontend DUT (.*);

   ////////////////////
   // clock and watchdog

   initial begin
      fe_clk = 1'b0;
      forever #50 fe_clk = ~fe_clk;
   end

   always @(posedge fe_clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // helpers

   function automatic logic [7:0] lcg_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];   // middle bits spread better
   endfunction

   task automatic check_val(input logic [79:0] actual, input logic [79:0] expected,
                            input string what);
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
      end
   endtask

   // newest byte sits at window bits 63:56
   task automatic load_rules(input int set);
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         rules[r] = '0;
      end
      if (set == 1) begin
         rules[0] = '{pattern: 64'hA5 << 56, mask: 64'hFF << 56, enable: 1'b1,
                      trig_enable: 1'b0};
         rules[1] = '{pattern: 64'h05 << 56, mask: 64'h0F << 56, enable: 1'b1,
                      trig_enable: 1'b0};   // low nibble only
         rules[2] = '{pattern: 64'hA5 << 56, mask: 64'hFF << 56, enable: 1'b0,
                      trig_enable: 1'b0};   // disabled so its count stays 0
      end
      else if (set == 2) begin
         rules[0] = '{pattern: 64'hA5 << 56, mask: 64'hFF << 56, enable: 1'b1,
                      trig_enable: 1'b0};
         rules[3] = '{pattern: 64'h3C << 56, mask: 64'hFF << 56, enable: 1'b1,
                      trig_enable: 1'b1};
      end
   endtask

   ////////////////////
   // reference model

   // one rising edge with the inputs now driven
   task automatic model_advance();
      trace_pkg::window_t    win;
      trace_pkg::rule_mask_t bits, te;
      logic                  sync_ok, aligned, strobe, pat_edge, ext_edge;
      for (int i = 0; i < `TRACE_WINDOW_W; i++) begin
         win[i] = m_buf[`TRACE_WINDOW_W-1-i];   // oldest bit at 0
      end
      sync_ok = (win[63:48] == `TRACE_SYNC_HEAD) && (win[7:0] == `TRACE_SYNC_TAIL);
      case (m_width_r)
         3'd4:    aligned = (m_align % 2 == 0);
         3'd2:    aligned = (m_align % 4 == 0);
         3'd1:    aligned = (m_align == 0);
         default: aligned = 1'b0;
      endcase
      strobe = m_locked && aligned;
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         te[r]   = rules[r].trig_enable;
         bits[r] = ((win & rules[r].mask) == (rules[r].pattern & rules[r].mask)) &&
                   rules[r].enable && strobe && (m_cap_r || rules[r].trig_enable);
      end
      pat_edge = (arm || capturing) && |(bits & te) && !(|(m_bits_r & te));
      ext_edge = ext_trig && !m_ext_r && ext_trig_enable;
      // next state
      m_trig  = pat_edge || ext_edge;
      m_event = |bits;
      if (|bits) begin
         m_report = '{rules: bits, data: win};
      end
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         if (bits[r]) m_counts[r] = m_counts[r] + 1'b1;
      end
      if (strobe) m_bits_r = bits;
      m_cap_r = capturing;
      m_ext_r = ext_trig;
      if (resync || (trace_width != m_width_r)) begin
         m_locked = 1'b0;
         m_align  = '0;
      end
      else if (!m_locked && sync_ok) begin
         m_locked = 1'b1;
         m_align  = 1;
      end
      else if (m_locked) begin
         m_align = m_align + 1'b1;
      end
      m_width_r = trace_width;
      // lane 0 is earliest and shifts in first
      for (int i = 0; i < trace_width; i++) begin
         m_buf = {m_buf[`TRACE_WINDOW_W-2:0], trace_data[i]};
      end
   endtask

   // drive one chunk and compare at the next falling edge
   task automatic run_cycle(input trace_pkg::lanes_t d);
      trace_data = d;
      model_advance();
      @(negedge fe_clk);
      check_val(locked, m_locked, "locked");
      check_val(match_event, m_event, "match_event");
      check_val(report, m_report, "report");
      check_val(trigger, m_trig, "trigger");
      for (int r = 0; r < `TRACE_NUM_RULES; r++) begin
         check_val(counts[r], m_counts[r], $sformatf("counts[%0d]", r));
      end
      if (trigger) trig_seen++;
   endtask

   task automatic apply_entry(input entry_t e);
      bit                q [$];
      logic [7:0]        b;
      trace_pkg::lanes_t d;
      load_rules(e.rset);
      trace_width     = e.width;
      capturing       = e.cap;
      arm             = e.arm;
      ext_trig        = e.ext;
      ext_trig_enable = e.ext_en;
      resync          = e.resync;
      if (e.kind == 1) begin
         // run of ones ending in a single 0 on the last lane and a filler byte after
         repeat (63 + e.width) q.push_back(1'b1);
         q.push_back(1'b0);
      end
      for (int n = 0; n < ((e.kind == 1) ? 1 : e.nbytes); n++) begin
         b = (e.kind == 2) ? e.value[7:0] : lcg_byte();
         for (int i = 0; i < 8; i++) q.push_back(b[i]);   // lsb first
      end
      trig_seen = 0;
      while (q.size() > 0) begin
         d = '0;
         for (int i = 0; i < e.width; i++) d[i] = q.pop_front();
         run_cycle(d);
         resync   = 1'b0;   // pulses last one cycle
         ext_trig = 1'b0;
      end
      check_val(locked, e.exp_locked, "locked at entry end");
      check_val(trig_seen, e.exp_trigs, "trigger pulses in entry");
   endtask

   ////////////////////
   // main sequence

   initial begin
      //          wid kind val  nb set cap arm ext een rsy lck trg
      tbl[0]  = '{4, 0, 0,    8, 0, 0, 0, 0, 0, 0, 0, 0};   // noise without lock
      tbl[1]  = '{4, 1, 0,    0, 0, 0, 0, 0, 0, 0, 1, 0};
      tbl[2]  = '{4, 2, 'hA5, 4, 1, 1, 0, 0, 0, 0, 1, 0};   // two rules at once
      tbl[3]  = '{4, 2, 'hA5, 4, 1, 1, 0, 0, 0, 1, 0, 0};   // resync then A5 unlocked
      tbl[4]  = '{2, 1, 0,    0, 0, 0, 0, 0, 0, 0, 1, 0};
      tbl[5]  = '{2, 2, 'h3C, 3, 2, 0, 1, 0, 0, 0, 1, 1};   // single pattern trigger
      tbl[6]  = '{1, 0, 0,    2, 0, 0, 0, 0, 0, 0, 0, 0};   // width change
      tbl[7]  = '{1, 1, 0,    0, 0, 0, 0, 0, 0, 0, 1, 0};
      tbl[8]  = '{1, 2, 'hA5, 2, 1, 1, 0, 0, 0, 0, 1, 0};
      tbl[9]  = '{1, 2, 'hA5, 2, 1, 0, 0, 0, 0, 0, 1, 0};   // capture off so no match
      tbl[10] = '{1, 0, 0,    1, 0, 0, 0, 1, 1, 0, 1, 1};   // ext trigger
      tbl[11] = '{1, 0, 0,    1, 0, 0, 0, 1, 0, 0, 1, 0};   // ext masked
      reset           = 1'b1;
      trace_data      = '0;
      trace_width     = 3'd4;
      resync          = 1'b0;
      capturing       = 1'b0;
      arm             = 1'b0;
      ext_trig        = 1'b0;
      ext_trig_enable = 1'b0;
      load_rules(0);
      m_buf = '0;
      m_width_r = '0;
      m_align = '0;
      m_locked = 1'b0;
      m_cap_r = 1'b0;
      m_ext_r = 1'b0;
      m_trig = 1'b0;
      m_event = 1'b0;
      m_bits_r = '0;
      m_report = '0;
      for (int r = 0; r < `TRACE_NUM_RULES; r++) m_counts[r] = '0;
      repeat (2) @(posedge fe_clk);
      @(negedge fe_clk);
      reset = 1'b0;
      for (int k = 0; k < NUM_ENTRIES; k++) begin
         apply_entry(tbl[k]);
      end
      check_val(counts[2], 0, "disabled rule count");
      $display("run complete, %0d errors", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end
      else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_deserializer.sv
hdl/sync_tracker.sv
hdl/pattern_matcher.sv
hdl/trace_frontend.sv
bench/tb_trace_frontend.sv
